/* include/fpnorm_consts.svh */
/*
 * fpnorm constants
 * lane count, field widths, bus widths and per-lane register map
 */
`ifndef FPNORM_CONSTS_SVH
`define FPNORM_CONSTS_SVH

// number of normalization lanes, power of two (2, 4 or 8)
`define NORM_LANES 4

// operand fields
`define MANT_W 52
`define EXP_W 11
`define LZ_W 6

// wishbone widths
`define WB_DW 32
`define LANE_SEL_W $clog2(`NORM_LANES)
// 6 with four lanes: lane index above a 16-byte window
`define WB_AW (`LANE_SEL_W + 4)

// word offsets inside a lane window
`define REG_MANT_LO 2'd0
`define REG_MANT_HI 2'd1
`define REG_STATUS 2'd2

`endif

/* hdl/fpnorm_pkg.sv */
/*
 * fpnorm types
 * width typedefs, operand and result structs, decoded bus select
 */
`include "fpnorm_consts.svh"

package fpnorm_pkg;

   // widths with a meaning
   typedef logic [`MANT_W-1:0] mant_t;
   typedef logic [`EXP_W-1:0] exp_t;
   typedef logic [`LZ_W-1:0] lz_count_t;
   typedef logic [`LANE_SEL_W-1:0] lane_sel_t;
   typedef logic [1:0] reg_sel_t;

   // operand handed to a lane on start
   typedef struct packed {
      exp_t exponent;
      mant_t frac;
   } norm_op_t;

   // registered lane result
   typedef struct packed {
      exp_t exponent;
      mant_t frac;
      lz_count_t count;
      logic zero;
      logic clamped;
      logic done;
   } norm_res_t;

   // decoded read address
   typedef struct packed {
      lane_sel_t lane;
      reg_sel_t word;
   } bus_sel_t;

endpackage

/* hdl/lzc52.sv */
/*
 * lzc52: combinational leading-zero counter for a 52-bit fraction
 * split 32/16/4, each part a tree of 2-bit and 4-bit stages
 * zero input gives count 0 and valid 0
 */
`timescale 1ns/1ps
`include "fpnorm_consts.svh"

module lzc52 import fpnorm_pkg::*; (
   input mant_t b,
   output lz_count_t count,
   output logic valid
);

   // 2-bit stage, returns {valid, position}
   function automatic logic [1:0] lz2(input logic [1:0] v);
      return {v[1] | v[0], ~v[1]};
   endfunction

   // 4-bit stage, returns {valid, count[1:0]}
   function automatic logic [2:0] lz4(input logic [3:0] v);
      logic [1:0] hi;
      logic [1:0] lo;
      hi = lz2(v[3:2]);
      lo = lz2(v[1:0]);
      return {hi[1] | lo[1], hi[1] ? {1'b0, hi[0]} : {1'b1, lo[0]}};
   endfunction

   // 16-bit stage from four nibbles, returns {valid, count[3:0]}
   function automatic logic [4:0] lz16(input logic [15:0] v);
      logic [2:0] n3;
      logic [2:0] n2;
      logic [2:0] n1;
      logic [2:0] n0;
      logic [2:0] top8;
      logic [2:0] bot8;
      n3 = lz4(v[15:12]);
      n2 = lz4(v[11:8]);
      n1 = lz4(v[7:4]);
      n0 = lz4(v[3:0]);
      // pair nibbles into bytes
      top8 = n3[2] ? {1'b0, n3[1:0]} : {1'b1, n2[1:0]};
      bot8 = n1[2] ? {1'b0, n1[1:0]} : {1'b1, n0[1:0]};
      return {n3[2] | n2[2] | n1[2] | n0[2],
              (n3[2] | n2[2]) ? {1'b0, top8} : {1'b1, bot8}};
   endfunction

   // 32-bit stage, two halves, returns {valid, count[4:0]}
   function automatic logic [5:0] lz32(input logic [31:0] v);
      logic [4:0] hi;
      logic [4:0] lo;
      hi = lz16(v[31:16]);
      lo = lz16(v[15:0]);
      return {hi[4] | lo[4], hi[4] ? {1'b0, hi[3:0]} : {1'b1, lo[3:0]}};
   endfunction

   logic [5:0] part32;
   logic [4:0] part16;
   logic [2:0] part4;

   // upper 32, middle 16, bottom 4 bits of the fraction
   always_comb begin
      part32 = lz32(b[51:20]);
      part16 = lz16(b[19:4]);
      part4 = lz4(b[3:0]);
   end

   // middle part starts at 32, bottom part at 48
   always_comb begin
      valid = part32[5] | part16[4] | part4[2];
      if (part32[5]) begin
         count = {1'b0, part32[4:0]};
      end else if (part16[4]) begin
         count = {2'b10, part16[3:0]};
      end else if (part4[2]) begin
         count = {4'b1100, part4[1:0]};
      end else begin
         count = '0;
      end
   end

endmodule

/* hdl/norm_lane.sv */
/*
 * norm_lane: one normalization lane
 * low-word staging, leading-zero count, exponent-clamped left shift,
 * registered result with zero, clamped and done flags
 */
`timescale 1ns/1ps
`include "fpnorm_consts.svh"

module norm_lane import fpnorm_pkg::*; (
   input logic clk,
   input logic reset,
   input logic lo_we,
   input logic [`WB_DW-1:0] lo_data,
   input logic start,
   input norm_op_t op,
   output norm_res_t res
);

   logic [31:0] lo_q;
   mant_t full_frac;
   lz_count_t lz_cnt;
   logic lz_valid;
   logic clamp;
   lz_count_t shift;
   exp_t exp_next;

   // staged low fraction word, kept until overwritten
   always_ff @(posedge clk) begin
      if (lo_we) begin
         lo_q <= lo_data;
      end
   end

   // upper bits come with the start, low bits from staging
   assign full_frac = {op.frac[`MANT_W-1:32], lo_q};

   lzc52 lzc_i (
      .b(full_frac),
      .count(lz_cnt),
      .valid(lz_valid)
   );

   // shift limited by exponent, never below zero
   always_comb begin
      clamp = exp_t'(lz_cnt) > op.exponent;
      if (clamp) begin
         shift = lz_count_t'(op.exponent);
      end else begin
         shift = lz_cnt;
      end
      // zero fraction flushes the exponent too
      if (lz_valid) begin
         exp_next = op.exponent - exp_t'(shift);
      end else begin
         exp_next = '0;
      end
   end

   // result registered one edge after the start pulse
   always_ff @(posedge clk) begin
      if (reset) begin
         res <= '0;
      end else if (start) begin
         res.exponent <= exp_next;
         res.frac <= full_frac << shift;
         res.count <= lz_cnt;
         res.zero <= ~lz_valid;
         res.clamped <= clamp;
         res.done <= 1'b1;
      end
   end

endmodule

/* hdl/wb_dispatch.sv */
/*
 * wb_dispatch: wishbone classic slave front end
 * single-cycle ack, lane/word decode, byte-lane masking,
 * low-word write enables, start pulses and registered read select
 */
`timescale 1ns/1ps
`include "fpnorm_consts.svh"

module wb_dispatch import fpnorm_pkg::*; (
   input logic clk,
   input logic reset,
   input logic wb_cyc,
   input logic wb_stb,
   input logic wb_we,
   input logic [`WB_AW-1:0] wb_adr,
   input logic [`WB_DW-1:0] wb_dat_w,
   input logic [`WB_DW/8-1:0] wb_sel,
   output logic wb_ack,
   output logic [`NORM_LANES-1:0] lo_we,
   output logic [`WB_DW-1:0] lo_data,
   output logic [`NORM_LANES-1:0] start,
   output norm_op_t op,
   output bus_sel_t rd_sel
);

   // unselected byte lanes write as zero
   function automatic logic [`WB_DW-1:0] byte_mask(input logic [`WB_DW/8-1:0] sel,
                                                   input logic [`WB_DW-1:0] d);
      logic [`WB_DW-1:0] m;
      m = '0;
      for (int i = 0; i < `WB_DW/8; i++) begin
         if (sel[i]) begin
            m[8*i +: 8] = d[8*i +: 8];
         end
      end
      return m;
   endfunction

   logic req;
   bus_sel_t dec;
   logic [`WB_DW-1:0] wdata;

   // new cycle only while ack is low, so no back-to-back acks
   always_comb begin
      req = wb_cyc & wb_stb & ~wb_ack;
      dec.lane = wb_adr[`WB_AW-1:4];
      dec.word = wb_adr[3:2];
      wdata = byte_mask(wb_sel, wb_dat_w);
   end

   // ack and strobes, all registered on the acking edge
   always_ff @(posedge clk) begin
      if (reset) begin
         wb_ack <= 1'b0;
         lo_we <= '0;
         start <= '0;
      end else begin
         wb_ack <= req;
         lo_we <= '0;
         start <= '0;
         if (req && wb_we) begin
            case (dec.word)
               `REG_MANT_LO: lo_we[dec.lane] <= 1'b1;
               `REG_MANT_HI: start[dec.lane] <= 1'b1;
               default: ;
            endcase
         end
      end
   end

   // payload, shared by all lanes
   always_ff @(posedge clk) begin
      if (req) begin
         rd_sel <= dec;
         lo_data <= wdata;
         // hi word: frac 51:32 in 19:0, exponent in 30:20
         op.frac <= {wdata[19:0], 32'h0};
         op.exponent <= wdata[30:20];
      end
   end

endmodule

/* hdl/result_collect.sv */
/*
 * result_collect: read-data mux
 * selects one lane result and formats fraction low,
 * fraction high with exponent, or status into a 32-bit word
 */
`timescale 1ns/1ps
`include "fpnorm_consts.svh"

module result_collect import fpnorm_pkg::*; (
   input bus_sel_t rd_sel,
   input norm_res_t res [`NORM_LANES],
   output logic [`WB_DW-1:0] wb_dat_r
);

   norm_res_t pick;

   always_comb begin
      pick = res[rd_sel.lane];
      case (rd_sel.word)
         `REG_MANT_LO: begin
            wb_dat_r = pick.frac[31:0];
         end
         `REG_MANT_HI: begin
            // same layout as the write side
            wb_dat_r = {1'b0, pick.exponent, pick.frac[`MANT_W-1:32]};
         end
         `REG_STATUS: begin
            // count 5:0, zero 8, clamped 9, done 10
            wb_dat_r = {21'h0, pick.done, pick.clamped, pick.zero, 2'b00, pick.count};
         end
         default: begin
            wb_dat_r = '0;
         end
      endcase
   end

endmodule

/* hdl/fpnorm_top.sv */
/*
 * fpnorm_top: normalization engine top level
 * wishbone dispatcher, generate loop of lanes, result collector
 */
`timescale 1ns/1ps
`include "fpnorm_consts.svh"

module fpnorm_top import fpnorm_pkg::*; (
   input logic clk,
   input logic reset,
   input logic wb_cyc,
   input logic wb_stb,
   input logic wb_we,
   input logic [`WB_AW-1:0] wb_adr,
   input logic [`WB_DW-1:0] wb_dat_w,
   input logic [`WB_DW/8-1:0] wb_sel,
   output logic [`WB_DW-1:0] wb_dat_r,
   output logic wb_ack
);

   logic [`NORM_LANES-1:0] lo_we;
   logic [`WB_DW-1:0] lo_data;
   logic [`NORM_LANES-1:0] start;
   norm_op_t op;
   bus_sel_t rd_sel;
   norm_res_t lane_res [`NORM_LANES];

   wb_dispatch dispatch_i (
      .clk(clk),
      .reset(reset),
      .wb_cyc(wb_cyc),
      .wb_stb(wb_stb),
      .wb_we(wb_we),
      .wb_adr(wb_adr),
      .wb_dat_w(wb_dat_w),
      .wb_sel(wb_sel),
      .wb_ack(wb_ack),
      .lo_we(lo_we),
      .lo_data(lo_data),
      .start(start),
      .op(op),
      .rd_sel(rd_sel)
   );

   // operand and low data broadcast, enables per lane
   for (genvar i = 0; i < `NORM_LANES; i++) begin : g_lane
      norm_lane lane_i (
         .clk(clk),
         .reset(reset),
         .lo_we(lo_we[i]),
         .lo_data(lo_data),
         .start(start[i]),
         .op(op),
         .res(lane_res[i])
      );
   end

   result_collect collect_i (
      .rd_sel(rd_sel),
      .res(lane_res),
      .wb_dat_r(wb_dat_r)
   );

endmodule

/* tests/fpnorm_tb.sv */
/*
 * fpnorm_tb: table-driven testbench for fpnorm_top
 * wishbone read and write tasks, reference model, lfsr stimulus,
 * value checker, after-reset and byte-enable checks, watchdog
 */
`timescale 1ns/1ps
`include "fpnorm_consts.svh"

module fpnorm_tb import fpnorm_pkg::*;;

   localparam int NUM_FIXED = 8;
   // multiple of the lane count, so every group fills all lanes
   localparam int NUM_CASES = 24;
   localparam int TIMEOUT_CYCLES = NUM_CASES * 40 + 10;

   logic clk;
   logic reset;
   logic wb_cyc;
   logic wb_stb;
   logic wb_we;
   logic [`WB_AW-1:0] wb_adr;
   logic [`WB_DW-1:0] wb_dat_w;
   logic [`WB_DW/8-1:0] wb_sel;
   logic [`WB_DW-1:0] wb_dat_r;
   logic wb_ack;

   // stimulus columns and expected read words
   lane_sel_t tbl_lane [NUM_CASES];
   exp_t tbl_exp [NUM_CASES];
   mant_t tbl_frac [NUM_CASES];
   logic [31:0] tbl_w0 [NUM_CASES];
   logic [31:0] tbl_w1 [NUM_CASES];
   logic [31:0] tbl_w2 [NUM_CASES];

   // byte enables for the next bus cycle
   logic [`WB_DW/8-1:0] byte_en;
   logic [31:0] lfsr;
   int value_errors;
   int bus_timeouts;

   fpnorm_top dut_i (
      .clk(clk),
      .reset(reset),
      .wb_cyc(wb_cyc),
      .wb_stb(wb_stb),
      .wb_we(wb_we),
      .wb_adr(wb_adr),
      .wb_dat_w(wb_dat_w),
      .wb_sel(wb_sel),
      .wb_dat_r(wb_dat_r),
      .wb_ack(wb_ack)
   );

   always #5 clk = ~clk;

   // fibonacci lfsr, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   // one lfsr step per bit taken
   task automatic take_bits(input int n, output logic [63:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v = {v[62:0], lfsr[0]};
      end
   endtask

   // reference: loop count, clamp to exponent, shift
   task automatic model_norm(input exp_t e, input mant_t f, output logic [31:0] w0,
                             output logic [31:0] w1, output logic [31:0] w2);
      int lz;
      int sh;
      logic clamped;
      exp_t e_out;
      mant_t f_out;
      // highest set bit wins, 52 means no bit set
      lz = 52;
      for (int i = 0; i < 52; i++) begin
         if (f[i]) begin
            lz = 51 - i;
         end
      end
      w2 = '0;
      w2[10] = 1'b1;
      if (lz == 52) begin
         // zero fraction: everything reads 0 except zero and done
         w0 = '0;
         w1 = '0;
         w2[8] = 1'b1;
      end else begin
         clamped = lz > int'(e);
         sh = clamped ? int'(e) : lz;
         e_out = exp_t'(int'(e) - sh);
         f_out = f << sh;
         w0 = f_out[31:0];
         w1 = {1'b0, e_out, f_out[51:32]};
         w2[5:0] = lz[5:0];
         w2[9] = clamped;
      end
   endtask

   // one classic cycle, ack expected within 8 cycles
   task automatic bus_access(input logic we, input lane_sel_t lane, input reg_sel_t word,
                             input logic [31:0] wdata, output logic [31:0] rdata);
      int waited;
      wb_adr = {lane, word, 2'b00};
      wb_dat_w = wdata;
      wb_we = we;
      wb_sel = byte_en;
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      rdata = '0;
      for (waited = 0; waited < 8; waited++) begin
         @(posedge clk);
         #1;
         if (wb_ack) begin
            break;
         end
      end
      if (wb_ack) begin
         rdata = wb_dat_r;
      end else begin
         $display("bus %s of lane %0d word %0d got no ack within 8 cycles",
                  we ? "write" : "read", lane, word);
         bus_timeouts++;
      end
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
   endtask

   task automatic bus_write(input lane_sel_t lane, input reg_sel_t word,
                            input logic [31:0] data);
      logic [31:0] unused;
      bus_access(1'b1, lane, word, data, unused);
   endtask

   task automatic bus_read(input lane_sel_t lane, input reg_sel_t word,
                           output logic [31:0] data);
      bus_access(1'b0, lane, word, '0, data);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected) begin
         $display("** Error: %s = %h, expected %h at %0t", name, got, expected, $time);
         value_errors++;
      end
   endtask

   // read one word and compare
   task automatic read_check(input lane_sel_t lane, input reg_sel_t word,
                             input logic [31:0] expected);
      logic [31:0] got;
      bus_read(lane, word, got);
      check_value($sformatf("wb_dat_r lane %0d word %0d", lane, word), got, expected);
   endtask

   // directed rows first, then lfsr rows with masked widths
   task automatic fill_table();
      logic [63:0] r;
      int width;
      mant_t mask;
      tbl_exp[0] = 11'd1023;
      tbl_frac[0] = 52'h8_1234_5678_9abc;
      tbl_exp[1] = 11'd1030;
      tbl_frac[1] = 52'h0_8765_4321_0fed;
      tbl_exp[2] = 11'd60;
      tbl_frac[2] = 52'h0_0000_0000_0001;
      // k = 51 with exponent exactly 51
      tbl_exp[3] = 11'd51;
      tbl_frac[3] = 52'h0_0000_0000_0001;
      tbl_exp[4] = 11'd5;
      tbl_frac[4] = 52'h0_0000_0001_0000;
      tbl_exp[5] = 11'd1023;
      tbl_frac[5] = 52'h0;
      // exponent 0 clamps to no shift at all
      tbl_exp[6] = 11'd0;
      tbl_frac[6] = 52'h4_0000_0000_0000;
      tbl_exp[7] = 11'd20;
      tbl_frac[7] = 52'h0_0000_8000_0000;
      for (int i = NUM_FIXED; i < NUM_CASES; i++) begin
         take_bits(52, r);
         tbl_frac[i] = r[51:0];
         take_bits(6, r);
         width = int'(r[5:0]) % 53;
         // width 52 wraps to all ones
         mask = (mant_t'(1) << width) - mant_t'(1);
         tbl_frac[i] = tbl_frac[i] & mask;
         take_bits(11, r);
         tbl_exp[i] = r[10:0];
         // small exponents half the time, for clamps
         take_bits(1, r);
         if (r[0]) begin
            tbl_exp[i] = tbl_exp[i] & 11'h03f;
         end
      end
      for (int i = 0; i < NUM_CASES; i++) begin
         tbl_lane[i] = lane_sel_t'(i % `NORM_LANES);
         model_norm(tbl_exp[i], tbl_frac[i], tbl_w0[i], tbl_w1[i], tbl_w2[i]);
      end
   endtask

   initial begin
      #(TIMEOUT_CYCLES * 10);
      $display("watchdog: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors found");
      $finish;
   end

   initial begin
      logic [31:0] sel_w0;
      logic [31:0] sel_w1;
      logic [31:0] sel_w2;
      clk = 1'b0;
      reset = 1'b1;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
      wb_adr = '0;
      wb_dat_w = '0;
      wb_sel = '0;
      byte_en = '1;
      lfsr = 32'hb66b_b79e;
      value_errors = 0;
      bus_timeouts = 0;
      fill_table();
      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;

      // all lanes idle and cleared after reset
      for (int l = 0; l < `NORM_LANES; l++) begin
         for (int w = 0; w < 4; w++) begin
            read_check(lane_sel_t'(l), reg_sel_t'(w), 32'h0);
         end
      end
      // staging word 0 alone starts nothing
      bus_write(lane_sel_t'(0), `REG_MANT_LO, 32'hdead_beef);
      read_check(lane_sel_t'(0), `REG_STATUS, 32'h0);
      read_check(lane_sel_t'(0), `REG_MANT_LO, 32'h0);

      // one group fills every lane before any read
      for (int base = 0; base < NUM_CASES; base += `NORM_LANES) begin
         for (int i = base; i < base + `NORM_LANES; i++) begin
            bus_write(tbl_lane[i], `REG_MANT_LO, tbl_frac[i][31:0]);
            bus_write(tbl_lane[i], `REG_MANT_HI,
                      {1'b0, tbl_exp[i], tbl_frac[i][51:32]});
         end
         for (int i = base; i < base + `NORM_LANES; i++) begin
            read_check(tbl_lane[i], `REG_MANT_LO, tbl_w0[i]);
            read_check(tbl_lane[i], `REG_MANT_HI, tbl_w1[i]);
            read_check(tbl_lane[i], `REG_STATUS, tbl_w2[i]);
            read_check(tbl_lane[i], 2'd3, 32'h0);
         end
      end

      // bytes 0 and 2 only, onto a cleared staging word
      bus_write(lane_sel_t'(1), `REG_MANT_LO, 32'h0);
      byte_en = 4'b0101;
      bus_write(lane_sel_t'(1), `REG_MANT_LO, 32'h1122_3344);
      byte_en = '1;
      // exponent 0, so the fraction comes back unshifted
      bus_write(lane_sel_t'(1), `REG_MANT_HI, 32'h0);
      model_norm(11'd0, {20'h0, 32'h0022_0044}, sel_w0, sel_w1, sel_w2);
      read_check(lane_sel_t'(1), `REG_MANT_LO, sel_w0);
      read_check(lane_sel_t'(1), `REG_MANT_HI, sel_w1);
      read_check(lane_sel_t'(1), `REG_STATUS, sel_w2);

      $display("value mismatches: %0d, bus timeouts: %0d", value_errors, bus_timeouts);
      if (value_errors == 0 && bus_timeouts == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

/* vlog.f */
+incdir+include
hdl/fpnorm_pkg.sv
hdl/lzc52.sv
hdl/norm_lane.sv
hdl/wb_dispatch.sv
hdl/result_collect.sv
hdl/fpnorm_top.sv
tests/fpnorm_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the fpnorm testbench with Verilator
# exit status 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=fpnorm_sim
log_file=sim.log

verilator --binary --timing \
   --top-module fpnorm_tb \
   --Mdir "$build_dir" \
   -o "$sim_bin" \
   -f vlog.f
status=$?
if [ "$status" -ne 0 ]; then
   echo "verilator compile failed with status $status"
   exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "No errors" "$log_file"; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed, see $log_file"
   exit 1
fi
